/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int xlen = 64;                      // RV64 register and pc width

    typedef logic [4:0]      reg_addr_t;           // x0..x31
    typedef logic [xlen-1:0] xword_t;

    // Major opcodes handled by the core; anything else decodes as illegal
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,                                   // Signed compare
        alu_sltu,                                  // Unsigned compare
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra                                    // Arithmetic right shift
    } alu_op_e;

    typedef enum logic [2:0] {
        kind_alu,                                  // R-type and I-type math
        kind_lui,
        kind_auipc,
        kind_jal,
        kind_jalr,
        kind_branch,
        kind_illegal
    } instr_kind_e;

    typedef struct packed {
        xword_t      pc;
        logic [31:0] instr;
    } issue_t;                                     // 96 bits

    typedef struct packed {
        xword_t      pc;
        instr_kind_e kind;
        alu_op_e     alu_op;
        logic [2:0]  br_funct3;                    // Branch condition code
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        xword_t      imm;                          // Sign extended
        logic        use_imm;                      // Second operand from imm
    } decoded_t;

    typedef struct packed {
        xword_t    pc;
        reg_addr_t rd;
        xword_t    wb_value;
        logic      wb_en;
        xword_t    next_pc;
        logic      illegal;
    } retire_t;                                    // 199 bits

endpackage

`default_nettype wire

/* hdl/int_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module int_regfile (
    input  wire logic              clk_1hz,
    input  wire logic              reset_n,
    input  wire rv_pkg::reg_addr_t rs1,
    input  wire rv_pkg::reg_addr_t rs2,
    output rv_pkg::xword_t         rs1_value,
    output rv_pkg::xword_t         rs2_value,
    input  wire logic              wr_en,
    input  wire rv_pkg::reg_addr_t wr_addr,
    input  wire rv_pkg::xword_t    wr_data
);

    rv_pkg::xword_t regs [1:31];                                        // x0 has no storage

    // Combinational reads with x0 forced to zero
    assign rs1_value = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == 5'd0) ? '0 : regs[rs2];

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin                    // Drop writes to x0
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/int_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module int_alu (
    input  wire rv_pkg::decoded_t dec_data,
    input  wire rv_pkg::xword_t   rs1_value,
    input  wire rv_pkg::xword_t   rs2_value,
    output rv_pkg::retire_t       exec_result
);

    rv_pkg::xword_t op_b;
    logic [5:0]     shamt;
    rv_pkg::xword_t alu_out;
    rv_pkg::xword_t link;
    rv_pkg::xword_t pc_target;
    rv_pkg::xword_t jalr_target;
    logic           br_taken;
    logic           is_illegal;

    assign op_b        = dec_data.use_imm ? dec_data.imm : rs2_value;  // I-type vs R-type
    assign shamt       = op_b[5:0];                                     // RV64 shift amount
    assign link        = dec_data.pc + 64'd4;                           // Also the fall-through pc
    assign pc_target   = dec_data.pc + dec_data.imm;                    // AUIPC, JAL, branches
    assign jalr_target = (rs1_value + dec_data.imm) & ~64'd1;           // Bit 0 cleared
    assign is_illegal  = (dec_data.kind == rv_pkg::kind_illegal);

    always_comb begin
        case (dec_data.alu_op)
            rv_pkg::alu_add:  alu_out = rs1_value + op_b;
            rv_pkg::alu_sub:  alu_out = rs1_value - op_b;
            rv_pkg::alu_slt:  alu_out = {63'b0, $signed(rs1_value) < $signed(op_b)};
            rv_pkg::alu_sltu: alu_out = {63'b0, rs1_value < op_b};
            rv_pkg::alu_and:  alu_out = rs1_value & op_b;
            rv_pkg::alu_or:   alu_out = rs1_value | op_b;
            rv_pkg::alu_xor:  alu_out = rs1_value ^ op_b;
            rv_pkg::alu_sll:  alu_out = rs1_value << shamt;
            rv_pkg::alu_srl:  alu_out = rs1_value >> shamt;
            rv_pkg::alu_sra:  alu_out = rv_pkg::xword_t'($signed(rs1_value) >>> shamt);
            default:          alu_out = '0;
        endcase
    end

    // Branch condition always compares the two registers
    always_comb begin
        case (dec_data.br_funct3)
            3'b000:  br_taken = (rs1_value == rs2_value);                       // BEQ
            3'b001:  br_taken = (rs1_value != rs2_value);                       // BNE
            3'b100:  br_taken = ($signed(rs1_value) <  $signed(rs2_value));     // BLT
            3'b101:  br_taken = ($signed(rs1_value) >= $signed(rs2_value));     // BGE
            3'b110:  br_taken = (rs1_value <  rs2_value);                       // BLTU
            3'b111:  br_taken = (rs1_value >= rs2_value);                       // BGEU
            default: br_taken = 1'b0;
        endcase
    end

    always_comb begin
        exec_result         = '0;
        exec_result.pc      = dec_data.pc;
        exec_result.rd      = dec_data.rd;
        exec_result.illegal = is_illegal;
        exec_result.wb_en   = !is_illegal && (dec_data.kind != rv_pkg::kind_branch);
        exec_result.next_pc = link;                                     // Default pc + 4
        case (dec_data.kind)
            rv_pkg::kind_alu: begin
                exec_result.wb_value = alu_out;
            end
            rv_pkg::kind_lui: begin
                exec_result.wb_value = dec_data.imm;
            end
            rv_pkg::kind_auipc: begin
                exec_result.wb_value = pc_target;
            end
            rv_pkg::kind_jal: begin
                exec_result.wb_value = link;
                exec_result.next_pc  = pc_target;
            end
            rv_pkg::kind_jalr: begin
                exec_result.wb_value = link;
                exec_result.next_pc  = jalr_target;
            end
            rv_pkg::kind_branch: begin
                if (br_taken) exec_result.next_pc = pc_target;
            end
            default: ;                                                  // Illegal keeps zero value
        endcase
    end

endmodule

`default_nettype wire

/* hdl/instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input  wire logic           clk_1hz,
    input  wire logic           reset_n,
    input  wire logic           issue_valid,
    input  wire rv_pkg::issue_t issue_data,
    output logic                issue_ready,
    input  wire logic           adv,
    output logic                dec_valid,
    output rv_pkg::decoded_t    dec_data
);

    logic [31:0]      instr;
    rv_pkg::opcode_e  opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    rv_pkg::xword_t   imm_i;
    rv_pkg::xword_t   imm_u;
    rv_pkg::xword_t   imm_j;
    rv_pkg::xword_t   imm_b;
    logic             op_f7_ok;
    logic             issue_fire;
    rv_pkg::decoded_t dec_next;

    assign instr  = issue_data.instr;
    assign opcode = rv_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};                     // ADDI etc, JALR
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};              // LUI, AUIPC
    assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};                                // JAL offset
    assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};                                 // Branch offset

    // Only SUB and SRA may use the alternate funct7 in OP
    assign op_f7_ok = (funct7 == 7'b0000000) ||
                      (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        dec_next           = '0;
        dec_next.pc        = issue_data.pc;
        dec_next.rd        = instr[11:7];
        dec_next.rs1       = instr[19:15];
        dec_next.rs2       = instr[24:20];
        dec_next.br_funct3 = funct3;
        dec_next.kind      = rv_pkg::kind_illegal;                       // Until proven known
        dec_next.alu_op    = rv_pkg::alu_add;
        case (opcode)
            rv_pkg::opc_lui: begin
                dec_next.kind = rv_pkg::kind_lui;
                dec_next.imm  = imm_u;
            end
            rv_pkg::opc_auipc: begin
                dec_next.kind = rv_pkg::kind_auipc;
                dec_next.imm  = imm_u;
            end
            rv_pkg::opc_jal: begin
                dec_next.kind = rv_pkg::kind_jal;
                dec_next.imm  = imm_j;
            end
            rv_pkg::opc_jalr: begin
                dec_next.imm = imm_i;
                if (funct3 == 3'b000) dec_next.kind = rv_pkg::kind_jalr;
            end
            rv_pkg::opc_branch: begin
                dec_next.imm = imm_b;
                if (funct3 != 3'b010 && funct3 != 3'b011) dec_next.kind = rv_pkg::kind_branch;
            end
            rv_pkg::opc_op_imm: begin
                dec_next.kind    = rv_pkg::kind_alu;
                dec_next.imm     = imm_i;
                dec_next.use_imm = 1'b1;
                case (funct3)
                    3'b000: dec_next.alu_op = rv_pkg::alu_add;
                    3'b010: dec_next.alu_op = rv_pkg::alu_slt;
                    3'b011: dec_next.alu_op = rv_pkg::alu_sltu;
                    3'b100: dec_next.alu_op = rv_pkg::alu_xor;
                    3'b110: dec_next.alu_op = rv_pkg::alu_or;
                    3'b111: dec_next.alu_op = rv_pkg::alu_and;
                    3'b001: begin
                        dec_next.alu_op = rv_pkg::alu_sll;
                        if (funct7[6:1] != 6'b000000) dec_next.kind = rv_pkg::kind_illegal;
                    end
                    default: begin                                      // 101 right shifts
                        if (funct7[6:1] == 6'b000000) begin
                            dec_next.alu_op = rv_pkg::alu_srl;
                        end else if (funct7[6:1] == 6'b010000) begin
                            dec_next.alu_op = rv_pkg::alu_sra;
                        end else begin
                            dec_next.kind = rv_pkg::kind_illegal;        // Bad shift funct6
                        end
                    end
                endcase
            end
            rv_pkg::opc_op: begin
                dec_next.kind = op_f7_ok ? rv_pkg::kind_alu : rv_pkg::kind_illegal;
                case (funct3)
                    3'b000: dec_next.alu_op = funct7[5] ? rv_pkg::alu_sub : rv_pkg::alu_add;
                    3'b001: dec_next.alu_op = rv_pkg::alu_sll;
                    3'b010: dec_next.alu_op = rv_pkg::alu_slt;
                    3'b011: dec_next.alu_op = rv_pkg::alu_sltu;
                    3'b100: dec_next.alu_op = rv_pkg::alu_xor;
                    3'b101: dec_next.alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                    3'b110: dec_next.alu_op = rv_pkg::alu_or;
                    default: dec_next.alu_op = rv_pkg::alu_and;
                endcase
            end
            default: ;                                                  // Loads, CSR, word ops
        endcase
    end

    assign issue_ready = !dec_valid || adv;                             // Slot free or leaving
    assign issue_fire  = issue_valid && issue_ready;

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            dec_valid <= 1'b0;
            dec_data  <= '0;
        end else if (issue_fire) begin
            dec_valid <= 1'b1;
            dec_data  <= dec_next;
        end else if (adv) begin
            dec_valid <= 1'b0;                                          // Drained, nothing new
        end
    end

endmodule

`default_nettype wire

/* hdl/retire_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module retire_stage (
    input  wire logic            clk_1hz,
    input  wire logic            reset_n,
    input  wire logic            dec_valid,
    input  wire rv_pkg::retire_t exec_result,
    output logic                 adv,
    output logic                 wr_en,
    output rv_pkg::reg_addr_t    wr_addr,
    output rv_pkg::xword_t       wr_data,
    output logic                 retire_valid,
    input  wire logic            retire_ready,
    output rv_pkg::retire_t      retire_data
);

    // Second slot takes a new record when empty or when its record leaves
    assign adv = dec_valid && (!retire_valid || retire_ready);

    // Write-back lands on the same edge that loads the retire register
    assign wr_en   = adv && exec_result.wb_en;
    assign wr_addr = exec_result.rd;
    assign wr_data = exec_result.wb_value;

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            retire_valid <= 1'b0;
            retire_data  <= '0;
        end else if (adv) begin
            retire_valid <= 1'b1;
            retire_data  <= exec_result;
        end else if (retire_ready) begin
            retire_valid <= 1'b0;                                       // Consumed, slot empty
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core (
    input  wire logic           clk_1hz,
    input  wire logic           reset_n,
    input  wire logic           issue_valid,
    input  wire rv_pkg::issue_t issue_data,
    output logic                issue_ready,
    output logic                retire_valid,
    output rv_pkg::retire_t     retire_data,
    input  wire logic           retire_ready
);

    logic              dec_valid;
    rv_pkg::decoded_t  dec_data;
    logic              adv;                                             // First slot moves
    rv_pkg::xword_t    rs1_value;
    rv_pkg::xword_t    rs2_value;
    rv_pkg::retire_t   exec_result;
    logic              wr_en;
    rv_pkg::reg_addr_t wr_addr;
    rv_pkg::xword_t    wr_data;

    instr_decoder u_decoder (
        .clk_1hz     (clk_1hz),
        .reset_n     (reset_n),
        .issue_valid (issue_valid),
        .issue_data  (issue_data),
        .issue_ready (issue_ready),
        .adv         (adv),
        .dec_valid   (dec_valid),
        .dec_data    (dec_data)
    );

    int_regfile u_regfile (
        .clk_1hz   (clk_1hz),
        .reset_n   (reset_n),
        .rs1       (dec_data.rs1),
        .rs2       (dec_data.rs2),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    int_alu u_alu (
        .dec_data    (dec_data),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .exec_result (exec_result)
    );

    retire_stage u_retire (
        .clk_1hz      (clk_1hz),
        .reset_n      (reset_n),
        .dec_valid    (dec_valid),
        .exec_result  (exec_result),
        .adv          (adv),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_data  (retire_data)
    );

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int half_period  = 5,                  // ns
    parameter int reset_cycles = 5
) (
    output logic clk_1hz,
    output logic reset_n
);

    initial begin
        clk_1hz = 1'b0;
        forever #(half_period) clk_1hz = ~clk_1hz;
    end

    initial begin
        reset_n = 1'b0;
        repeat (reset_cycles) @(posedge clk_1hz);
        #1 reset_n = 1'b1;                           // Release just after an edge
    end

endmodule

`default_nettype wire

/* tests/rv_core_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_properties (
    input wire logic            clk_1hz,
    input wire logic            reset_n,
    input wire logic            retire_valid,
    input wire logic            retire_ready,
    input wire rv_pkg::retire_t retire_data
);

    stable_while_stalled: assert property (@(posedge clk_1hz) disable iff (!reset_n)
        retire_valid && !retire_ready |=> $stable(retire_data))
        else $error("retire_data changed while waiting for retire_ready");

    valid_held: assert property (@(posedge clk_1hz) disable iff (!reset_n)
        retire_valid && !retire_ready |=> retire_valid)
        else $error("retire_valid dropped before the record was consumed");

    // Pipe is empty on the first edge out of reset
    idle_after_reset: assert property (@(posedge clk_1hz) $rose(reset_n) |-> !retire_valid)
        else $error("retire_valid high on the first edge after reset");

endmodule

`default_nettype wire

/* tests/rv_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;

    localparam int timeout_cycles = 200;

    logic            clk_1hz;
    logic            reset_n;
    logic            issue_valid;
    rv_pkg::issue_t  issue_data;
    logic            issue_ready;
    logic            retire_valid;
    rv_pkg::retire_t retire_data;
    logic            retire_ready;

    integer          seed    = 32'h1849;                // Stimulus stream
    integer          bp_seed = 32'h1849;                // retire_ready stream
    rv_pkg::xword_t  model_regs [0:31];                 // Entry 0 never written
    rv_pkg::retire_t expected_q [$];                    // Acceptance order
    int              accept_q [$];                      // Edge index of each acceptance
    int              edge_count = 0;
    logic            bp_mode;                           // Random retire_ready when set
    logic            check_latency;
    rv_pkg::xword_t  cur_pc;

    tb_clock_gen #(.half_period(5), .reset_cycles(5)) u_clk (
        .clk_1hz (clk_1hz),
        .reset_n (reset_n)
    );

    rv_core dut (
        .clk_1hz      (clk_1hz),
        .reset_n      (reset_n),
        .issue_valid  (issue_valid),
        .issue_data   (issue_data),
        .issue_ready  (issue_ready),
        .retire_valid (retire_valid),
        .retire_data  (retire_data),
        .retire_ready (retire_ready)
    );

    bind rv_core rv_core_properties u_props (
        .clk_1hz      (clk_1hz),
        .reset_n      (reset_n),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_data  (retire_data)
    );

    task automatic report_mismatch(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Mismatch against reference model");
    endtask

    task automatic abort_run(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_value(input string field, input rv_pkg::xword_t got,
                               input rv_pkg::xword_t exp);
        if (got !== exp) report_mismatch($sformatf("%s got %h expected %h", field, got, exp));
    endtask

    task automatic check_flag(input string field, input logic got, input logic exp);
        if (got !== exp) report_mismatch($sformatf("%s got %b expected %b", field, got, exp));
    endtask

    task automatic check_retire(input rv_pkg::retire_t got, input rv_pkg::retire_t exp);
        check_value("pc", got.pc, exp.pc);
        check_value("wb_value", got.wb_value, exp.wb_value);
        check_value("next_pc", got.next_pc, exp.next_pc);
        check_flag("wb_en", got.wb_en, exp.wb_en);
        check_flag("illegal", got.illegal, exp.illegal);
        if (got !== exp) report_mismatch($sformatf("rd got %0d expected %0d", got.rd, exp.rd));
    endtask

    function automatic rv_pkg::xword_t alu_model(input logic [2:0] f3, input logic alt,
                                                 input rv_pkg::xword_t a, input rv_pkg::xword_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[5:0];
            3'b010:  return {63'b0, $signed(a) < $signed(b)};
            3'b011:  return {63'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? rv_pkg::xword_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input rv_pkg::xword_t a,
                                          input rv_pkg::xword_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;                     // BGEU
        endcase
    endfunction

    // Executes one item on the model registers in acceptance order
    function automatic rv_pkg::retire_t ref_execute(input rv_pkg::issue_t it);
        rv_pkg::retire_t r;
        logic [31:0]     w;
        rv_pkg::xword_t  a;
        rv_pkg::xword_t  b;
        rv_pkg::xword_t  imm_i;
        logic            ok;
        w         = it.instr;
        a         = model_regs[w[19:15]];
        b         = model_regs[w[24:20]];
        imm_i     = {{52{w[31]}}, w[31:20]};
        ok        = 1'b1;
        r         = '0;
        r.pc      = it.pc;
        r.rd      = w[11:7];
        r.next_pc = it.pc + 64'd4;
        case (w[6:0])
            7'h37: r.wb_value = {{32{w[31]}}, w[31:12], 12'h000};          // LUI
            7'h17: r.wb_value = it.pc + {{32{w[31]}}, w[31:12], 12'h000};  // AUIPC
            7'h6f: begin                                                    // JAL
                r.wb_value = it.pc + 64'd4;
                r.next_pc  = it.pc + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'h67: begin                                                    // JALR
                ok         = (w[14:12] == 3'b000);
                r.wb_value = it.pc + 64'd4;
                r.next_pc  = (a + imm_i) & ~64'd1;
            end
            7'h63: begin
                ok = (w[14:13] != 2'b01);                                   // 010, 011 unused
                if (ok && branch_model(w[14:12], a, b))
                    r.next_pc = it.pc + {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            7'h13: begin
                if (w[14:12] == 3'b001) ok = (w[31:26] == 6'b000000);
                if (w[14:12] == 3'b101) ok = (w[31:26] == 6'b000000 || w[31:26] == 6'b010000);
                r.wb_value = alu_model(w[14:12], w[14:12] == 3'b101 && w[30], a, imm_i);
            end
            7'h33: begin
                ok = (w[31:25] == 7'h00) ||
                     (w[31:25] == 7'h20 && (w[14:12] == 3'b000 || w[14:12] == 3'b101));
                r.wb_value = alu_model(w[14:12], w[30], a, b);
            end
            default: ok = 1'b0;                                             // Loads, CSR, W ops
        endcase
        if (!ok) begin
            r.wb_value = '0;
            r.next_pc  = it.pc + 64'd4;
        end
        r.illegal = !ok;
        r.wb_en   = ok && (w[6:0] != 7'h63);
        if (r.wb_en && r.rd != 5'd0) model_regs[r.rd] = r.wb_value;
        return r;
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    // Valid R-type or I-type operation with random fields
    function automatic logic [31:0] rand_alu_instr();
        logic [31:0] r;
        logic [6:0]  f7;
        r  = $random(seed);
        f7 = (r[30] && (r[14:12] == 3'b000 || r[14:12] == 3'b101)) ? 7'h20 : 7'h00;
        if (r[6]) return {f7, r[24:7], 7'h33};                              // rs2 rs1 f3 rd
        if (r[13:12] == 2'b01) return {f7[6:1], r[25:20], r[19:7], 7'h13};  // Shift immediate
        return {r[31:7], 7'h13};
    endfunction

    task automatic issue_one(input logic [31:0] word);
        int waited;
        waited           = 0;
        issue_valid      = 1'b1;
        issue_data.pc    = cur_pc;
        issue_data.instr = word;
        @(negedge clk_1hz);                                                 // Handshake settled
        while (!issue_ready) begin
            waited++;
            if (waited > timeout_cycles) abort_run("issue_ready stayed low, item not accepted");
            @(negedge clk_1hz);
        end
        expected_q.push_back(ref_execute(issue_data));
        accept_q.push_back(edge_count + 1);
        cur_pc = cur_pc + 64'd4;
        @(posedge clk_1hz);
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0) begin
            waited++;
            if (waited > timeout_cycles) abort_run("records still outstanding after timeout");
            @(posedge clk_1hz);
        end
        #1;
    endtask

    always @(posedge clk_1hz) edge_count <= edge_count + 1;

    always @(posedge clk_1hz) begin
        #1;
        retire_ready = bp_mode ? (($random(bp_seed) & 1) != 0) : 1'b1;
    end

    // Samples each record half a cycle before the edge that consumes it
    always @(negedge clk_1hz) begin
        if (reset_n && retire_valid && retire_ready) begin
            if (expected_q.size() == 0) abort_run("DUT retired a record that was never issued");
            check_retire(retire_data, expected_q.pop_front());
            if (check_latency && edge_count + 1 - accept_q[0] != 2)
                report_mismatch($sformatf("latency %0d edges, expected 2",
                                          edge_count + 1 - accept_q[0]));
            void'(accept_q.pop_front());
        end
    end

    initial begin
        logic [31:0] rnd;
        int          waited;
        issue_valid   = 1'b0;
        issue_data    = '0;
        retire_ready  = 1'b1;
        bp_mode       = 1'b0;
        check_latency = 1'b1;
        waited        = 0;
        cur_pc        = 64'h0000_0000_8000_0000;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;

        while (reset_n !== 1'b1) begin
            waited++;
            if (waited > timeout_cycles) abort_run("reset was never released");
            @(posedge clk_1hz);
        end
        @(posedge clk_1hz);
        #1;
        check_flag("retire_valid after reset", retire_valid, 1'b0);
        check_flag("issue_ready after reset", issue_ready, 1'b1);

        for (int r = 1; r < 32; r++) begin                                  // Seed every register
            rnd = $random(seed);
            issue_one({rnd[31:12], 5'(r), 7'h37});                          // LUI
            issue_one({rnd[11:0], 5'(r), 3'b000, 5'(r), 7'h13});            // ADDI
        end
        repeat (300) issue_one(rand_alu_instr());

        issue_one({7'h00, 5'd5, 5'd6, 3'b000, 5'd0, 7'h33});                // ADD x0
        issue_one({12'd77, 5'd3, 3'b000, 5'd0, 7'h13});                     // ADDI x0
        issue_one({7'h00, 5'd0, 5'd0, 3'b000, 5'd9, 7'h33});                // x9 = x0 + x0
        issue_one({12'h7ff, 5'd0, 3'b110, 5'd10, 7'h13});                   // ORI from x0

        repeat (160) begin
            rnd = $random(seed);
            case (rnd[31:30])
                2'b00: issue_one(b_type(rnd[12:0], rnd[3] ? rnd[17:13] : rnd[22:18],
                                        rnd[17:13], rnd[25:23]));           // Same regs half
                2'b01: issue_one(j_type(rnd[20:0], rnd[25:21]));
                2'b10: issue_one({rnd[11:0], rnd[16:12], 3'b000, rnd[21:17], 7'h67});
                default: issue_one(rand_alu_instr());
            endcase
        end

        issue_one({12'h008, 5'd0, 3'b011, 5'd1, 7'h03});                    // LD
        issue_one({7'h00, 5'd2, 5'd1, 3'b011, 5'd16, 7'h23});               // SD
        issue_one(32'h0000_0073);                                           // ECALL
        issue_one({12'h300, 5'd6, 3'b001, 5'd5, 7'h73});                    // CSRRW
        issue_one({7'h00, 5'd9, 5'd8, 3'b000, 5'd7, 7'h3b});                // ADDW
        issue_one({12'h001, 5'd8, 3'b000, 5'd7, 7'h1b});                    // ADDIW
        issue_one({7'h01, 5'd9, 5'd8, 3'b000, 5'd7, 7'h33});                // MUL pattern
        issue_one({7'h20, 5'd9, 5'd8, 3'b001, 5'd7, 7'h33});                // SLL with alt bit
        issue_one({6'b010000, 6'd3, 5'd8, 3'b001, 5'd7, 7'h13});            // SLLI bad funct6
        issue_one({6'b000001, 6'd2, 5'd8, 3'b101, 5'd7, 7'h13});            // SRLI bad funct6
        issue_one({12'h0ff, 5'd1, 3'b001, 5'd4, 7'h67});                    // JALR funct3 1
        issue_one(32'h0ff0_000f);                                           // FENCE
        drain();

        check_latency = 1'b0;                                               // Stalls stretch it
        bp_mode       = 1'b1;
        repeat (150) issue_one(rand_alu_instr());
        drain();
        bp_mode = 1'b0;                                                     // Let strays leave
        repeat (5) @(posedge clk_1hz);                                      // Catch stray records

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hdl/rv_pkg.sv
hdl/int_regfile.sv
hdl/int_alu.sv
hdl/instr_decoder.sv
hdl/retire_stage.sv
hdl/rv_core.sv
tests/tb_clock_gen.sv
tests/rv_core_properties.sv
tests/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - files:
      - hdl/rv_pkg.sv
      - hdl/int_regfile.sv
      - hdl/int_alu.sv
      - hdl/instr_decoder.sv
      - hdl/retire_stage.sv
      - hdl/rv_core.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/rv_core_properties.sv
      - tests/rv_core_tb.sv
